// File: ring_bus_pkg.sv
package ring_bus_pkg;

  localparam int BUS_WIDTH   = 32;
  localparam int MASK_WIDTH  = BUS_WIDTH / 8;
  localparam int REGION_BITS = 8;
  localparam int OFFSET_BITS = BUS_WIDTH - REGION_BITS;

  typedef logic [BUS_WIDTH-1:0]  bus_word_t;
  typedef logic [MASK_WIDTH-1:0] byte_mask_t;

  // Upper byte picks the node, the rest is the byte offset inside it
  typedef union packed {
    logic [BUS_WIDTH-1:0] raw;
    struct packed {
      logic [REGION_BITS-1:0] region;
      logic [OFFSET_BITS-1:0] offset;
    } fields;
  } bus_addr_u;

  // Each mask bit widened to its byte lane
  function automatic bus_word_t lane_mask(input byte_mask_t mask);
    bus_word_t word;
    for (int b = 0; b < MASK_WIDTH; b++)
    begin
      word[8*b +: 8] = {8{mask[b]}};
    end
    return word;
  endfunction

endpackage

// File: periph_map_pkg.sv
package periph_map_pkg;

  // Region codes, upper address byte
  localparam logic [7:0] RAM_REGION  = 8'h00;
  localparam logic [7:0] LED_REGION  = 8'hC0;
  localparam logic [7:0] KEYS_REGION = 8'hC1;

  // 1024 words, 4 KiB byte window
  localparam int RAM_ADDR_BITS = 10;
  localparam int RAM_WORDS     = 1 << RAM_ADDR_BITS;

  // Register offsets inside the peripheral regions
  localparam logic [23:0] LED_VALUE_OFS  = 24'h000000;
  localparam logic [23:0] KEYS_LEVEL_OFS = 24'h000000;
  localparam logic [23:0] KEYS_PRESS_OFS = 24'h000004;

  localparam int NUM_LEDS = 8;
  localparam int NUM_KEYS = 2;

endpackage

// File: ring_ram.sv
`timescale 1ns/1ns

module ring_ram (
  input  logic                   clk,
  input  logic                   i_rst,

  input  logic                   i_bus_req,
  input  logic                   i_bus_ack,
  input  logic                   i_bus_write,
  input  ring_bus_pkg::bus_addr_u  i_bus_addr,
  input  ring_bus_pkg::bus_word_t  i_bus_data,
  input  ring_bus_pkg::byte_mask_t i_bus_rd_mask,
  input  ring_bus_pkg::byte_mask_t i_bus_wr_mask,

  output logic                   o_bus_req,
  output logic                   o_bus_ack,
  output logic                   o_bus_write,
  output ring_bus_pkg::bus_addr_u  o_bus_addr,
  output ring_bus_pkg::bus_word_t  o_bus_data,
  output ring_bus_pkg::byte_mask_t o_bus_rd_mask,
  output ring_bus_pkg::byte_mask_t o_bus_wr_mask
);
  import ring_bus_pkg::*;
  import periph_map_pkg::*;

  bus_word_t                mem [RAM_WORDS];
  logic [RAM_ADDR_BITS-1:0] word_idx;
  logic                     in_window;
  logic                     hit;
  bus_word_t                rd_word;

  assign word_idx  = i_bus_addr.raw[RAM_ADDR_BITS+1:2];
  assign in_window = (i_bus_addr.fields.offset[OFFSET_BITS-1:RAM_ADDR_BITS+2] == '0);
  assign hit       = i_bus_req && !i_bus_ack && (i_bus_addr.fields.region == RAM_REGION);

  // Beyond the window reads as zero
  assign rd_word = in_window ? mem[word_idx] : '0;

  always_ff @(posedge clk)
  begin
    if (hit && i_bus_write && in_window)
    begin
      for (int b = 0; b < MASK_WIDTH; b++)
      begin
        if (i_bus_wr_mask[b])
        begin
          mem[word_idx][8*b +: 8] <= i_bus_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      o_bus_req <= 1'b0;
      o_bus_ack <= 1'b0;
    end
    else
    begin
      o_bus_req <= i_bus_req;
      o_bus_ack <= i_bus_ack | hit;
    end
  end

  always_ff @(posedge clk)
  begin
    o_bus_write    <= i_bus_write;
    o_bus_addr.raw <= i_bus_addr.raw;
    o_bus_rd_mask  <= i_bus_rd_mask;
    o_bus_wr_mask  <= i_bus_wr_mask;
    if (hit && !i_bus_write)
    begin
      o_bus_data <= rd_word & lane_mask(i_bus_rd_mask);
    end
    else
    begin
      o_bus_data <= i_bus_data;
    end
  end

  // Master must name at least one byte on a write
  assert property (@(posedge clk) disable iff (i_rst)
    (hit && i_bus_write) |-> (i_bus_wr_mask != '0));

  // Nothing enters the ring already acknowledged without a request
  assert property (@(posedge clk) disable iff (i_rst)
    i_bus_ack |-> i_bus_req);

endmodule

// File: ring_led.sv
`timescale 1ns/1ns

module ring_led (
  input  logic                   clk,
  input  logic                   i_rst,

  input  logic                   i_bus_req,
  input  logic                   i_bus_ack,
  input  logic                   i_bus_write,
  input  ring_bus_pkg::bus_addr_u  i_bus_addr,
  input  ring_bus_pkg::bus_word_t  i_bus_data,
  input  ring_bus_pkg::byte_mask_t i_bus_rd_mask,
  input  ring_bus_pkg::byte_mask_t i_bus_wr_mask,

  output logic                   o_bus_req,
  output logic                   o_bus_ack,
  output logic                   o_bus_write,
  output ring_bus_pkg::bus_addr_u  o_bus_addr,
  output ring_bus_pkg::bus_word_t  o_bus_data,
  output ring_bus_pkg::byte_mask_t o_bus_rd_mask,
  output ring_bus_pkg::byte_mask_t o_bus_wr_mask,

  output logic [periph_map_pkg::NUM_LEDS-1:0] o_led
);
  import ring_bus_pkg::*;
  import periph_map_pkg::*;

  logic      hit;
  logic      at_value;
  bus_word_t rd_word;

  assign hit      = i_bus_req && !i_bus_ack && (i_bus_addr.fields.region == LED_REGION);
  assign at_value = (i_bus_addr.fields.offset == LED_VALUE_OFS);
  assign rd_word  = at_value ? BUS_WIDTH'(o_led) : '0;

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      o_bus_req <= 1'b0;
      o_bus_ack <= 1'b0;
      o_led     <= '0;
    end
    else
    begin
      o_bus_req <= i_bus_req;
      o_bus_ack <= i_bus_ack | hit;
      // Only byte lane 0 reaches the LEDs
      if (hit && i_bus_write && at_value && i_bus_wr_mask[0])
      begin
        o_led <= i_bus_data[NUM_LEDS-1:0];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    o_bus_write    <= i_bus_write;
    o_bus_addr.raw <= i_bus_addr.raw;
    o_bus_rd_mask  <= i_bus_rd_mask;
    o_bus_wr_mask  <= i_bus_wr_mask;
    if (hit && !i_bus_write)
    begin
      o_bus_data <= rd_word & lane_mask(i_bus_rd_mask);
    end
    else
    begin
      o_bus_data <= i_bus_data;
    end
  end

  // Ring comes out of reset empty
  assert property (@(posedge clk) $fell(i_rst) |=> !o_bus_req);

endmodule

// File: ring_keys.sv
`timescale 1ns/1ns

module ring_keys (
  input  logic                   clk,
  input  logic                   i_rst,

  input  logic                   i_bus_req,
  input  logic                   i_bus_ack,
  input  logic                   i_bus_write,
  input  ring_bus_pkg::bus_addr_u  i_bus_addr,
  input  ring_bus_pkg::bus_word_t  i_bus_data,
  input  ring_bus_pkg::byte_mask_t i_bus_rd_mask,
  input  ring_bus_pkg::byte_mask_t i_bus_wr_mask,

  output logic                   o_bus_req,
  output logic                   o_bus_ack,
  output logic                   o_bus_write,
  output ring_bus_pkg::bus_addr_u  o_bus_addr,
  output ring_bus_pkg::bus_word_t  o_bus_data,
  output ring_bus_pkg::byte_mask_t o_bus_rd_mask,
  output ring_bus_pkg::byte_mask_t o_bus_wr_mask,

  input  logic [periph_map_pkg::NUM_KEYS-1:0] i_key
);
  import ring_bus_pkg::*;
  import periph_map_pkg::*;

  logic [NUM_KEYS-1:0] key_meta;
  logic [NUM_KEYS-1:0] key_sync;
  logic [NUM_KEYS-1:0] key_prev;
  logic [NUM_KEYS-1:0] key_fall;
  logic [NUM_KEYS-1:0] press_q;
  logic [NUM_KEYS-1:0] press_clr;
  logic                hit;
  bus_word_t           rd_word;

  assign hit = i_bus_req && !i_bus_ack && (i_bus_addr.fields.region == KEYS_REGION);

  // Keys are active low, a press is a falling level
  assign key_fall = key_prev & ~key_sync;

  assign press_clr = (hit && i_bus_write && i_bus_wr_mask[0] &&
                      i_bus_addr.fields.offset == KEYS_PRESS_OFS) ?
                     i_bus_data[NUM_KEYS-1:0] : '0;

  always_comb
  begin
    rd_word = '0;
    if (i_bus_addr.fields.offset == KEYS_LEVEL_OFS)
      rd_word = BUS_WIDTH'(key_sync);
    else if (i_bus_addr.fields.offset == KEYS_PRESS_OFS)
      rd_word = BUS_WIDTH'(press_q);
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      key_meta  <= '1;
      key_sync  <= '1;
      key_prev  <= '1;
      press_q   <= '0;
      o_bus_req <= 1'b0;
      o_bus_ack <= 1'b0;
    end
    else
    begin
      key_meta  <= i_key;
      key_sync  <= key_meta;
      key_prev  <= key_sync;
      // New edge beats a clear of the same bit
      press_q   <= (press_q & ~press_clr) | key_fall;
      o_bus_req <= i_bus_req;
      o_bus_ack <= i_bus_ack | hit;
    end
  end

  always_ff @(posedge clk)
  begin
    o_bus_write    <= i_bus_write;
    o_bus_addr.raw <= i_bus_addr.raw;
    o_bus_rd_mask  <= i_bus_rd_mask;
    o_bus_wr_mask  <= i_bus_wr_mask;
    if (hit && !i_bus_write)
      o_bus_data <= rd_word & lane_mask(i_bus_rd_mask);
    else
      o_bus_data <= i_bus_data;
  end

  // A press bit appears only after its key level fell
  assert property (@(posedge clk) disable iff (i_rst)
    (press_q & ~$past(press_q) & ~($past(key_sync, 2) & ~$past(key_sync))) == '0);

endmodule

// File: ring_soc_top.sv
`timescale 1ns/1ns

module ring_soc_top (
  input  logic                   clk,
  input  logic                   i_rst,

  input  logic                   i_bus_req,
  input  logic                   i_bus_ack,
  input  logic                   i_bus_write,
  input  ring_bus_pkg::bus_addr_u  i_bus_addr,
  input  ring_bus_pkg::bus_word_t  i_bus_data,
  input  ring_bus_pkg::byte_mask_t i_bus_rd_mask,
  input  ring_bus_pkg::byte_mask_t i_bus_wr_mask,

  output logic                   o_bus_req,
  output logic                   o_bus_ack,
  output logic                   o_bus_write,
  output ring_bus_pkg::bus_addr_u  o_bus_addr,
  output ring_bus_pkg::bus_word_t  o_bus_data,
  output ring_bus_pkg::byte_mask_t o_bus_rd_mask,
  output ring_bus_pkg::byte_mask_t o_bus_wr_mask,

  output logic [periph_map_pkg::NUM_LEDS-1:0] o_led,
  input  logic [periph_map_pkg::NUM_KEYS-1:0] i_key
);
  import ring_bus_pkg::*;

  // RAM to LED hop
  logic       ram_led_req;
  logic       ram_led_ack;
  logic       ram_led_write;
  bus_addr_u  ram_led_addr;
  bus_word_t  ram_led_data;
  byte_mask_t ram_led_rd_mask;
  byte_mask_t ram_led_wr_mask;

  // LED to keys hop
  logic       led_keys_req;
  logic       led_keys_ack;
  logic       led_keys_write;
  bus_addr_u  led_keys_addr;
  bus_word_t  led_keys_data;
  byte_mask_t led_keys_rd_mask;
  byte_mask_t led_keys_wr_mask;

  ring_ram u_ram (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_bus_req     (i_bus_req),
    .i_bus_ack     (i_bus_ack),
    .i_bus_write   (i_bus_write),
    .i_bus_addr    (i_bus_addr),
    .i_bus_data    (i_bus_data),
    .i_bus_rd_mask (i_bus_rd_mask),
    .i_bus_wr_mask (i_bus_wr_mask),
    .o_bus_req     (ram_led_req),
    .o_bus_ack     (ram_led_ack),
    .o_bus_write   (ram_led_write),
    .o_bus_addr    (ram_led_addr),
    .o_bus_data    (ram_led_data),
    .o_bus_rd_mask (ram_led_rd_mask),
    .o_bus_wr_mask (ram_led_wr_mask)
  );

  ring_led u_led (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_bus_req     (ram_led_req),
    .i_bus_ack     (ram_led_ack),
    .i_bus_write   (ram_led_write),
    .i_bus_addr    (ram_led_addr),
    .i_bus_data    (ram_led_data),
    .i_bus_rd_mask (ram_led_rd_mask),
    .i_bus_wr_mask (ram_led_wr_mask),
    .o_bus_req     (led_keys_req),
    .o_bus_ack     (led_keys_ack),
    .o_bus_write   (led_keys_write),
    .o_bus_addr    (led_keys_addr),
    .o_bus_data    (led_keys_data),
    .o_bus_rd_mask (led_keys_rd_mask),
    .o_bus_wr_mask (led_keys_wr_mask),
    .o_led         (o_led)
  );

  // Last node closes the ring back to the master
  ring_keys u_keys (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_bus_req     (led_keys_req),
    .i_bus_ack     (led_keys_ack),
    .i_bus_write   (led_keys_write),
    .i_bus_addr    (led_keys_addr),
    .i_bus_data    (led_keys_data),
    .i_bus_rd_mask (led_keys_rd_mask),
    .i_bus_wr_mask (led_keys_wr_mask),
    .o_bus_req     (o_bus_req),
    .o_bus_ack     (o_bus_ack),
    .o_bus_write   (o_bus_write),
    .o_bus_addr    (o_bus_addr),
    .o_bus_data    (o_bus_data),
    .o_bus_rd_mask (o_bus_rd_mask),
    .o_bus_wr_mask (o_bus_wr_mask),
    .i_key         (i_key)
  );

endmodule

// File: tb_ring_soc.sv
`timescale 1ns/1ns

module tb_ring_soc;
  import ring_bus_pkg::*;
  import periph_map_pkg::*;

  localparam int MAX_TESTS      = 32;
  localparam int TIMEOUT_CYCLES = 20;

  logic                clk;
  logic                i_rst;
  logic                i_bus_req;
  logic                i_bus_ack;
  logic                i_bus_write;
  bus_addr_u           i_bus_addr;
  bus_word_t           i_bus_data;
  byte_mask_t          i_bus_rd_mask;
  byte_mask_t          i_bus_wr_mask;
  logic                o_bus_req;
  logic                o_bus_ack;
  logic                o_bus_write;
  bus_addr_u           o_bus_addr;
  bus_word_t           o_bus_data;
  byte_mask_t          o_bus_rd_mask;
  byte_mask_t          o_bus_wr_mask;
  logic [NUM_LEDS-1:0] o_led;
  logic [NUM_KEYS-1:0] i_key;

  // Stimulus table with expected responses
  string               t_name     [MAX_TESTS];
  logic                t_write    [MAX_TESTS];
  bus_word_t           t_addr     [MAX_TESTS];
  bus_word_t           t_data     [MAX_TESTS];
  byte_mask_t          t_wr_mask  [MAX_TESTS];
  byte_mask_t          t_rd_mask  [MAX_TESTS];
  logic [NUM_KEYS-1:0] t_key      [MAX_TESTS];
  logic                t_exp_ack  [MAX_TESTS];
  bus_word_t           t_exp_data [MAX_TESTS];
  logic [NUM_LEDS-1:0] t_exp_led  [MAX_TESTS];

  int                  num_tests;
  int                  seed;
  int                  pass_count;
  int                  fail_count;
  logic                test_ok;
  logic                timed_out;
  bus_word_t           ram_model [int];
  logic [NUM_LEDS-1:0] led_model;

  ring_soc_top u_dut (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_bus_req     (i_bus_req),
    .i_bus_ack     (i_bus_ack),
    .i_bus_write   (i_bus_write),
    .i_bus_addr    (i_bus_addr),
    .i_bus_data    (i_bus_data),
    .i_bus_rd_mask (i_bus_rd_mask),
    .i_bus_wr_mask (i_bus_wr_mask),
    .o_bus_req     (o_bus_req),
    .o_bus_ack     (o_bus_ack),
    .o_bus_write   (o_bus_write),
    .o_bus_addr    (o_bus_addr),
    .o_bus_data    (o_bus_data),
    .o_bus_rd_mask (o_bus_rd_mask),
    .o_bus_wr_mask (o_bus_wr_mask),
    .o_led         (o_led),
    .i_key         (i_key)
  );

  always #20 clk = ~clk;

  // One byte of ones per set mask bit
  function automatic bus_word_t expand_mask(input byte_mask_t mask);
    bus_word_t bits;
    for (int i = 0; i < 4; i++)
    begin
      bits[8*i +: 8] = mask[i] ? 8'hFF : 8'h00;
    end
    return bits;
  endfunction

  task automatic check_word(input string test, input string what,
                            input bus_word_t exp, input bus_word_t act);
    if (act !== exp)
    begin
      $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_mask(input string test, input string what,
                            input byte_mask_t exp, input byte_mask_t act);
    if (act !== exp)
    begin
      $display("ERR %s %s: expected %h, actual %h", test, what, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_ack(input string test, input string what,
                           input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %s %s: expected %b, actual %b", test, what, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_led(input string test, input logic [NUM_LEDS-1:0] exp,
                           input logic [NUM_LEDS-1:0] act);
    if (act !== exp)
    begin
      $display("ERR %s led: expected %h, actual %h", test, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic add_entry(input string name, input logic write, input bus_word_t addr,
                           input bus_word_t data, input byte_mask_t wr_mask,
                           input byte_mask_t rd_mask, input logic [NUM_KEYS-1:0] key,
                           input logic exp_ack, input bus_word_t exp_data);
    t_name[num_tests]     = name;
    t_write[num_tests]    = write;
    t_addr[num_tests]     = addr;
    t_data[num_tests]     = data;
    t_wr_mask[num_tests]  = wr_mask;
    t_rd_mask[num_tests]  = rd_mask;
    t_key[num_tests]      = key;
    t_exp_ack[num_tests]  = exp_ack;
    t_exp_data[num_tests] = exp_data;
    t_exp_led[num_tests]  = led_model;
    num_tests++;
  endtask

  task automatic add_ram_write(input string name, input bus_word_t addr, input byte_mask_t mask);
    bus_word_t data;
    bus_word_t old;
    int        idx;
    data = $random(seed);
    idx  = int'(addr[11:2]);
    old  = ram_model.exists(idx) ? ram_model[idx] : 'x;
    ram_model[idx] = (old & ~expand_mask(mask)) | (data & expand_mask(mask));
    add_entry(name, 1'b1, addr, data, mask, 4'h0, 2'b11, 1'b1, data);
  endtask

  task automatic add_ram_read(input string name, input bus_word_t addr, input byte_mask_t mask);
    bus_word_t exp;
    exp = ram_model[int'(addr[11:2])] & expand_mask(mask);
    add_entry(name, 1'b0, addr, 32'h0, 4'h0, mask, 2'b11, 1'b1, exp);
  endtask

  task automatic add_led_write(input string name, input bus_word_t data, input byte_mask_t mask);
    if (mask[0])
    begin
      led_model = data[NUM_LEDS-1:0];
    end
    add_entry(name, 1'b1, {LED_REGION, LED_VALUE_OFS}, data, mask, 4'h0, 2'b11, 1'b1, data);
  endtask

  task automatic add_key_read(input string name, input logic [23:0] ofs,
                              input logic [NUM_KEYS-1:0] key, input bus_word_t exp);
    add_entry(name, 1'b0, {KEYS_REGION, ofs}, 32'h0, 4'h0, 4'hF, key, 1'b1, exp);
  endtask

  task automatic build_table();
    num_tests = 0;
    led_model = '0;
    add_ram_write("ram_wr_full_a", 32'h0000_0010, 4'b1111);
    add_ram_read("ram_rd_full_a", 32'h0000_0010, 4'b1111);
    add_ram_write("ram_wr_part_a", 32'h0000_0010, 4'b0101);
    add_ram_read("ram_rd_part_a", 32'h0000_0010, 4'b1110);
    add_ram_write("ram_wr_full_b", 32'h0000_0FFC, 4'b1111);
    add_ram_write("ram_wr_part_b", 32'h0000_0FFC, 4'b1000);
    add_ram_read("ram_rd_full_b", 32'h0000_0FFC, 4'b1111);
    add_ram_write("ram_wr_full_c", 32'h0000_0200, 4'b1111);
    add_ram_read("ram_rd_low_c", 32'h0000_0200, 4'b0011);
    // Region 0x50 has no node
    add_entry("unmapped_rd", 1'b0, 32'h5000_1000, 32'h1234_5678, 4'h0, 4'hF, 2'b11,
              1'b0, 32'h1234_5678);
    add_entry("unmapped_wr", 1'b1, 32'h5000_1000, 32'hCAFE_F00D, 4'hF, 4'h0, 2'b11,
              1'b0, 32'hCAFE_F00D);
    add_led_write("led_wr", 32'h0000_00A5, 4'b1111);
    add_entry("led_rd", 1'b0, {LED_REGION, LED_VALUE_OFS}, 32'h0, 4'h0, 4'hF, 2'b11,
              1'b1, {24'h0, led_model});
    add_led_write("led_wr_no_lane0", 32'h0000_003C, 4'b1110);
    add_entry("led_rd_lane0", 1'b0, {LED_REGION, LED_VALUE_OFS}, 32'h0, 4'h0, 4'b0001,
              2'b11, 1'b1, {24'h0, led_model});
    add_entry("led_empty_ofs", 1'b0, {LED_REGION, 24'h000008}, 32'hFFFF_FFFF, 4'h0, 4'hF,
              2'b11, 1'b1, 32'h0);
    add_key_read("key_level_high", KEYS_LEVEL_OFS, 2'b11, 32'h3);
    add_key_read("key_level_low", KEYS_LEVEL_OFS, 2'b01, 32'h1);
    add_key_read("key_press_set", KEYS_PRESS_OFS, 2'b01, 32'h2);
    add_entry("key_press_clear", 1'b1, {KEYS_REGION, KEYS_PRESS_OFS}, 32'h2, 4'b0001,
              4'h0, 2'b01, 1'b1, 32'h2);
    add_key_read("key_press_zero", KEYS_PRESS_OFS, 2'b01, 32'h0);
  endtask

  task automatic drive_request(input logic write, input bus_word_t addr, input bus_word_t data,
                               input byte_mask_t wr_mask, input byte_mask_t rd_mask);
    i_bus_req      = 1'b1;
    i_bus_ack      = 1'b0;
    i_bus_write    = write;
    i_bus_addr.raw = addr;
    i_bus_data     = data;
    i_bus_wr_mask  = wr_mask;
    i_bus_rd_mask  = rd_mask;
  endtask

  task automatic idle_bus();
    i_bus_req      = 1'b0;
    i_bus_ack      = 1'b0;
    i_bus_write    = 1'b0;
    i_bus_addr.raw = '0;
    i_bus_data     = '0;
    i_bus_wr_mask  = '0;
    i_bus_rd_mask  = '0;
  endtask

  // Count edges since issue until the transaction comes back
  task automatic wait_return(input string name, input int start, output int waited);
    waited = start;
    while (o_bus_req !== 1'b1 && !timed_out)
    begin
      if (waited >= TIMEOUT_CYCLES)
      begin
        $display("Timeout: test %s got no returning request within %0d cycles", name, waited);
        timed_out = 1'b1;
        test_ok   = 1'b0;
      end
      else
      begin
        @(posedge clk);
        #2;
        waited++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (test_ok)
    begin
      pass_count++;
      $display("ok    %s", name);
    end
    else
    begin
      fail_count++;
      $display("FAIL  %s", name);
    end
  endtask

  task automatic run_test(input int n);
    int waited;
    test_ok = 1'b1;
    // Let a new key level through the synchronizer and edge detector
    if (i_key !== t_key[n])
    begin
      i_key = t_key[n];
      repeat (4) @(posedge clk);
      #2;
    end
    drive_request(t_write[n], t_addr[n], t_data[n], t_wr_mask[n], t_rd_mask[n]);
    @(posedge clk);
    #2;
    idle_bus();
    wait_return(t_name[n], 1, waited);
    if (!timed_out)
    begin
      check_ack(t_name[n], "ack", t_exp_ack[n], o_bus_ack);
      check_ack(t_name[n], "write", t_write[n], o_bus_write);
      check_word(t_name[n], "addr", t_addr[n], o_bus_addr.raw);
      check_word(t_name[n], "data", t_exp_data[n], o_bus_data);
      check_mask(t_name[n], "rd_mask", t_rd_mask[n], o_bus_rd_mask);
      check_mask(t_name[n], "wr_mask", t_wr_mask[n], o_bus_wr_mask);
      check_led(t_name[n], t_exp_led[n], o_led);
    end
    finish_test(t_name[n]);
  endtask

  // RAM write, LED read, RAM read back on consecutive cycles
  task automatic run_pipeline();
    bus_word_t data;
    bus_word_t exp [3];
    int        waited;
    test_ok = 1'b1;
    data    = $random(seed);
    exp[0]  = data;
    exp[1]  = {24'h0, led_model};
    exp[2]  = data;
    drive_request(1'b1, 32'h0000_0040, data, 4'hF, 4'h0);
    @(posedge clk);
    #2;
    drive_request(1'b0, {LED_REGION, LED_VALUE_OFS}, 32'h0, 4'h0, 4'hF);
    @(posedge clk);
    #2;
    drive_request(1'b0, 32'h0000_0040, 32'h0, 4'h0, 4'hF);
    @(posedge clk);
    #2;
    idle_bus();
    wait_return("pipeline", 3, waited);
    if (!timed_out)
    begin
      if (waited != 3)
      begin
        $display("pipeline: first transaction returned after %0d cycles instead of 3", waited);
        test_ok = 1'b0;
      end
      for (int k = 0; k < 3; k++)
      begin
        if (k > 0)
        begin
          @(posedge clk);
          #2;
        end
        check_ack("pipeline", $sformatf("req %0d", k), 1'b1, o_bus_req);
        check_ack("pipeline", $sformatf("ack %0d", k), 1'b1, o_bus_ack);
        check_word("pipeline", $sformatf("data %0d", k), exp[k], o_bus_data);
      end
    end
    finish_test("pipeline");
  endtask

  initial
  begin
    clk        = 1'b0;
    i_rst      = 1'b1;
    i_key      = 2'b11;
    seed       = 23028;
    pass_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;
    idle_bus();
    build_table();

    test_ok = 1'b1;
    repeat (10)
    begin
      @(posedge clk);
      #2;
      check_ack("reset", "req", 1'b0, o_bus_req);
      check_ack("reset", "ack", 1'b0, o_bus_ack);
      check_led("reset", '0, o_led);
    end
    i_rst = 1'b0;
    @(posedge clk);
    #2;
    check_ack("reset", "req after", 1'b0, o_bus_req);
    check_ack("reset", "ack after", 1'b0, o_bus_ack);
    check_led("reset", '0, o_led);
    finish_test("reset");

    for (int n = 0; n < num_tests && !timed_out; n++)
    begin
      run_test(n);
    end
    if (!timed_out)
    begin
      run_pipeline();
    end

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (!timed_out && fail_count == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
ring_bus_pkg.sv
periph_map_pkg.sv
ring_ram.sv
ring_led.sv
ring_keys.sv
ring_soc_top.sv
tb_ring_soc.sv

// File: Makefile
# Verilator flow for the ring bus subsystem

VERILATOR ?= verilator
TOP       ?= tb_ring_soc
RTL_TOP   ?= ring_soc_top
FILELIST  ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qx "No errors" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
